// File: test/cpu6Soc_trace.txt
# P <byte addr> <word>, T <test name>, S <store addr> <store data>
# X <marker store addr that raises extIrq> <ack store addr that drops it>
X 00000434 00000440
T alu
P 00000000 40000093
P 00000004 00500113
P 00000008 ffd00193
P 0000000c 00310233
P 00000010 0040a023
P 00000014 403102b3
P 00000018 0050a223
P 0000001c 00314333
P 00000020 0060a423
P 00000024 4011d393
P 00000028 00313433
P 0000002c 00441413
P 00000030 0083c3b3
P 00000034 0070a623
P 00000038 123454b7
P 0000003c 00001517
P 00000040 00a484b3
P 00000044 0090a823
S 00000400 00000002
S 00000404 00000008
S 00000408 fffffff8
S 0000040c ffffffee
S 00000410 1234603c
T branch
P 00000048 00310463
P 0000004c 0020aa23
P 00000050 0021c463
P 00000054 0030ac23
P 00000058 00317463
P 0000005c 008005ef
P 00000060 0030ac23
P 00000064 00b0ac23
P 00000068 00c58667
P 0000006c 00c0ae23
S 00000414 00000005
S 00000418 00000060
S 0000041c 0000006c
T loadstore
P 00000070 0290a023
P 00000074 0200a683
P 00000078 00168693
P 0000007c 02d0a223
S 00000420 1234603c
S 00000424 1234603d
T illegal
P 00000080 10000713
P 00000084 30571073
P 00000088 00000000
P 0000008c 0220a423
P 00000100 342022f3
P 00000104 0250a623
P 00000108 34102373
P 0000010c 0260a823
P 00000110 00430313
P 00000114 34131073
P 00000118 30200073
S 0000042c 00000002
S 00000430 00000088
S 00000428 00000005
T extirq
P 00000090 14000713
P 00000094 30571073
P 00000098 00100793
P 0000009c 00b79793
P 000000a0 3047a073
P 000000a4 30046073
P 000000a8 0220aa23
P 000000ac 000f8063
P 000000b0 0220ac23
P 00000140 00100f93
P 00000144 342022f3
P 00000148 0250ae23
P 0000014c 0400a023
P 00000150 00000013
P 00000154 00000013
P 00000158 30200073
S 00000434 00000005
S 0000043c 8000000b
S 00000440 00000000
S 00000438 00000005
T timer
P 000000b4 18000713
P 000000b8 30571073
P 000000bc 10000837
P 000000c0 08000893
P 000000c4 3048a073
P 000000c8 00000f93
P 000000cc 01000913
P 000000d0 01282223
P 000000d4 30046073
P 000000d8 000f8063
P 000000dc 0420a423
P 000000e0 0000006f
P 00000180 00100f93
P 00000184 342022f3
P 00000188 0450a223
P 0000018c fff00313
P 00000190 00682223
P 00000194 00000013
P 00000198 00000013
P 0000019c 30200073
S 00000444 80000007
S 00000448 00000005

// File: files.f
hw/cpu6Pkg.sv
hw/cpu6Controller.sv
hw/cpu6Excp.sv
hw/cpu6Datapath.sv
hw/cpu6Core.sv
hw/cpu6Timer.sv
hw/cpu6Soc.sv
test/cpu6Soc_props.sv
test/cpu6SocTb.sv

// File: Bender.yml
package:
  name: cpu6

sources:
  - hw/cpu6Pkg.sv
  - hw/cpu6Controller.sv
  - hw/cpu6Excp.sv
  - hw/cpu6Datapath.sv
  - hw/cpu6Core.sv
  - hw/cpu6Timer.sv
  - hw/cpu6Soc.sv
  - target: test
    files:
      - test/cpu6Soc_props.sv
      - test/cpu6SocTb.sv

// File: test/cpu6SocTb.sv
`timescale 1ns/1ps

module cpu6SocTb;
   import cpu6Pkg::*;

   localparam int MemWords   = 256;
   localparam int TailCycles = 20;
   localparam int SlackCycles = 200;

   logic clk;
   logic rstN;
   logic extIrq;
   wordT instr;
   wordT readData;
   wordT instrAddr;
   wordT dataAddr;
   wordT writeData;
   logic memWrite;
   logic memRead;

   wordT imem [0:MemWords-1];
   wordT dmem [0:MemWords-1];

   // expected stores in program order, each tagged with its test
   wordT  expAddr[$];
   wordT  expData[$];
   int    expTest[$];
   string testNames[$];
   int    testErrs[$];

   wordT markerAddr;
   wordT ackAddr;
   int   progWords;
   int   timeoutCycles;
   int   irqCount;
   int   errors;
   int   passedTests;
   bit   traceOk;
   bit   traceLoaded;
   bit   allSeen;

   cpu6Soc u_dut (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .readData  (readData),
      .extIrq    (extIrq),
      .instrAddr (instrAddr),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWrite  (memWrite),
      .memRead   (memRead)
   );

   // both memories answer in the same cycle, data only for a load
   assign instr    = imem[instrAddr[9:2]];
   assign readData = memRead ? dmem[dataAddr[9:2]] : 32'hBAD0_BAD0;

   always #10 clk = ~clk;

   task automatic loadTrace(output bit ok);
      int    fd;
      string line;
      string kind;
      string name;
      wordT  a;
      wordT  d;
      fd = $fopen("test/cpu6Soc_trace.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            void'($sscanf(line, "%s", kind));
            case (kind)
               "P": begin
                  void'($sscanf(line, "%s %h %h", kind, a, d));
                  imem[a[9:2]] = d;
                  progWords++;
               end
               "T": begin
                  void'($sscanf(line, "%s %s", kind, name));
                  testNames.push_back(name);
                  testErrs.push_back(0);
               end
               "S": begin
                  void'($sscanf(line, "%s %h %h", kind, a, d));
                  expAddr.push_back(a);
                  expData.push_back(d);
                  expTest.push_back(testNames.size() - 1);
               end
               "X": void'($sscanf(line, "%s %h %h", kind, markerAddr, ackAddr));
               default: begin
                  $display("trace record not understood: %s", line);
                  errors++;
               end
            endcase
         end
         $fclose(fd);
      end
   endtask

   task automatic reportTest(input int t);
      if (testErrs[t] == 0) begin
         $display("test %s: ok", testNames[t]);
         passedTests++;
      end else begin
         $display("test %s: %0d mismatches", testNames[t], testErrs[t]);
      end
   endtask

   task automatic checkStore(input wordT addr, input wordT data);
      int t;
      assert (expAddr.size() > 0) else begin
         $display("unexpected store of %h to %h after the last expected store", data, addr);
         errors++;
      end
      if (expAddr.size() > 0) begin
         t = expTest[0];
         assert (addr == expAddr[0] && data == expData[0]) else begin
            $display("FAILED %s: expected %h at %h, actual %h at %h",
                     testNames[t], expData[0], expAddr[0], data, addr);
            errors++;
            testErrs[t]++;
         end
         void'(expAddr.pop_front());
         void'(expData.pop_front());
         void'(expTest.pop_front());
         if (expTest.size() == 0 || expTest[0] != t)
            reportTest(t);
         if (expAddr.size() == 0)
            allSeen = 1'b1;
      end
   endtask

   // stores and the interrupt line are handled away from the rising edge
   always @(negedge clk) begin
      if (irqCount > 0) begin
         irqCount--;
         if (irqCount == 0)
            extIrq = 1'b1;
      end
      if (rstN && memWrite) begin
         dmem[dataAddr[9:2]] = writeData;
         checkStore(dataAddr, writeData);
         if (dataAddr == markerAddr)
            irqCount = 1 + ($urandom % 8);
         if (dataAddr == ackAddr)
            extIrq = 1'b0;
      end
   end

   initial begin
      void'($urandom(11));
      clk    = 1'b0;
      rstN   = 1'b0;
      extIrq = 1'b0;
      for (int i = 0; i < MemWords; i++) begin
         imem[i] = Nop;
         dmem[i] = 32'hDA00_0000 ^ (i * 4);
      end
      loadTrace(traceOk);
      if (!traceOk) begin
         $display("cannot open the trace file test/cpu6Soc_trace.txt");
         $display("TEST FAILED");
      end else begin
         timeoutCycles = 40 * progWords + SlackCycles;
         traceLoaded = 1'b1;
         repeat (10) @(negedge clk);
         rstN = 1'b1;
         wait (allSeen);
         // catch any stray store after the last expected one
         repeat (TailCycles) @(negedge clk);
         $display("%0d of %0d tests passed, %0d errors", passedTests, testNames.size(),
                  errors);
         if (errors == 0 && passedTests == testNames.size())
            $display("TEST PASSED");
         else
            $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      wait (traceLoaded);
      repeat (timeoutCycles) @(posedge clk);
      $display("watchdog: the program did not finish within %0d cycles", timeoutCycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: test/cpu6Soc_props.sv
`timescale 1ns/1ps

module cpu6CoreProps (
   input logic          clk,
   input logic          rstN,
   input cpu6Pkg::wordT pcF,
   input logic          memWrite,
   input logic          memRead,
   input logic          pcSrcE,
   input logic          flushPcEna
);

   // execute is empty right after reset
   assert property (@(posedge clk) !rstN |=> !memWrite)
      else $error("memWrite high in the cycle after reset");

   assert property (@(posedge clk) rstN |-> (pcF[1:0] == 2'b00))
      else $error("pcF %h is not word aligned", pcF);

   assert property (@(posedge clk) rstN |-> !(memWrite && memRead))
      else $error("memWrite and memRead high together");

   // the slot behind a redirect holds a bubble
   assert property (@(posedge clk) rstN && (pcSrcE || flushPcEna) |=> !memWrite)
      else $error("store issued while execute is invalid");

endmodule

bind cpu6Core cpu6CoreProps uProps (
   .clk        (clk),
   .rstN       (rstN),
   .pcF        (pcF),
   .memWrite   (memWrite),
   .memRead    (memRead),
   .pcSrcE     (pcSrcE),
   .flushPcEna (flushPcEna)
);

// File: hw/cpu6Soc.sv
`timescale 1ns/1ps

module cpu6Soc (
   input  logic          clk,
   input  logic          rstN,
   input  cpu6Pkg::wordT instr,
   input  cpu6Pkg::wordT readData,
   input  logic          extIrq,
   output cpu6Pkg::wordT instrAddr,
   output cpu6Pkg::wordT dataAddr,
   output cpu6Pkg::wordT writeData,
   output logic          memWrite,
   output logic          memRead
);
   import cpu6Pkg::*;

   wordT coreAddr;
   wordT coreRdata;
   wordT tmrRdata;
   logic coreWrite;
   logic coreRead;
   logic tmrHit;
   logic tmrIrq;

   // timer occupies a 16-byte window
   assign tmrHit = (coreAddr[Xlen-1:4] == TimerBase[Xlen-1:4]);

   assign dataAddr  = coreAddr;
   assign memWrite  = coreWrite & ~tmrHit;
   assign memRead   = coreRead & ~tmrHit;
   assign coreRdata = tmrHit ? tmrRdata : readData;

   cpu6Core uCore (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .readData  (coreRdata),
      .tmrIrq    (tmrIrq),
      .extIrq    (extIrq),
      .pcF       (instrAddr),
      .dataAddr  (coreAddr),
      .writeData (writeData),
      .memWrite  (coreWrite),
      .memRead   (coreRead)
   );

   cpu6Timer uTimer (
      .clk       (clk),
      .rstN      (rstN),
      .sel       (tmrHit),
      .write     (coreWrite),
      .addrLow   (coreAddr[2]),
      .writeData (writeData),
      .readData  (tmrRdata),
      .tmrIrq    (tmrIrq)
   );

endmodule

// File: hw/cpu6Timer.sv
`timescale 1ns/1ps

module cpu6Timer (
   input  logic          clk,
   input  logic          rstN,
   input  logic          sel,
   input  logic          write,
   input  logic          addrLow,
   input  cpu6Pkg::wordT writeData,
   output cpu6Pkg::wordT readData,
   output logic          tmrIrq
);
   import cpu6Pkg::*;

   wordT mtime;
   wordT mtimecmp;

   always_ff @(posedge clk) begin
      if (!rstN)
         mtime <= '0;
      else
         mtime <= mtime + wordT'(1);
   end

   // all ones keeps the interrupt quiet until software arms it
   always_ff @(posedge clk) begin
      if (!rstN)
         mtimecmp <= '1;
      else if (sel && write && addrLow)
         mtimecmp <= writeData;
   end

   assign readData = sel ? (addrLow ? mtimecmp : mtime) : '0;
   assign tmrIrq   = (mtime >= mtimecmp);

endmodule

// File: hw/cpu6Core.sv
`timescale 1ns/1ps

module cpu6Core (
   input  logic          clk,
   input  logic          rstN,
   input  cpu6Pkg::wordT instr,
   input  cpu6Pkg::wordT readData,
   input  logic          tmrIrq,
   input  logic          extIrq,
   output cpu6Pkg::wordT pcF,
   output cpu6Pkg::wordT dataAddr,
   output cpu6Pkg::wordT writeData,
   output logic          memWrite,
   output logic          memRead
);
   import cpu6Pkg::*;

   // decode stage
   wordT    instrD;
   logic    regWriteD;
   logic    memWriteD;
   logic    memToRegD;
   logic    aluSrcImmD;
   logic    jumpD;
   logic    jalrD;
   logic    auipcD;
   logic    luiD;
   logic    mretD;
   branchT  branchTypeD;
   aluCtrlT aluCtrlD;
   immSelT  immSelD;
   csrOpT   csrOpD;
   logic    csrUimmD;
   logic    illInstrD;
   logic    decValid;
   logic    stallD;
   logic    flushE;
   wordT    pcNext;

   // execute stage
   logic    validE;
   wordT    pcE;
   wordT    instrE;
   logic    regWriteE;
   logic    memWriteE;
   logic    memToRegE;
   logic    aluSrcImmE;
   logic    jumpE;
   logic    jalrE;
   logic    auipcE;
   logic    luiE;
   branchT  branchTypeE;
   aluCtrlT aluCtrlE;
   immSelT  immSelE;
   csrOpT   csrOpE;
   logic    csrUimmE;
   wordT    pcNextE;
   logic    pcSrcE;
   logic    csrInE;

   // trap unit and CSR state
   logic    flushPcEna;
   logic    trapEna;
   logic    irqTake;
   logic    mretTake;
   wordT    flushPc;
   wordT    trapCause;
   wordT    trapPc;
   wordT    mtvec;
   wordT    mepc;
   logic    mstatusMie;
   logic    mieMtie;
   logic    mieMeie;

   // the interrupted word is dropped and re-fetched after mret
   assign instrD = irqTake ? Nop : instr;

   // a taken branch in execute kills whatever sits in decode
   assign decValid = ~pcSrcE;
   // decode waits one cycle behind any CSR access
   assign stallD = csrInE;
   assign flushE = pcSrcE | flushPcEna | stallD;

   cpu6Controller uController (
      .instr      (instrD),
      .regWrite   (regWriteD),
      .memWrite   (memWriteD),
      .memToReg   (memToRegD),
      .aluSrcImm  (aluSrcImmD),
      .jump       (jumpD),
      .jalr       (jalrD),
      .auipc      (auipcD),
      .lui        (luiD),
      .mret       (mretD),
      .branchType (branchTypeD),
      .aluCtrl    (aluCtrlD),
      .immSel     (immSelD),
      .csrOp      (csrOpD),
      .csrUimm    (csrUimmD),
      .illInstr   (illInstrD)
   );

   cpu6Excp uExcp (
      .decValid (decValid),
      .illInstr (illInstrD),
      .mret     (mretD),
      .holdTrap (csrInE),
      .pcD      (pcF),
      .*
   );

   cpu6Datapath uDatapath (.*);

   always_comb begin
      if (pcSrcE)
         pcNext = pcNextE;
      else if (flushPcEna)
         pcNext = flushPc;
      else
         pcNext = pcF + wordT'(4);
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         pcF <= ResetVec;
      else if (!stallD)
         pcF <= pcNext;
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         validE <= 1'b0;
      else
         validE <= ~flushE;
   end

   // payload follows decode unless held; validE decides if it runs
   always_ff @(posedge clk) begin
      if (!stallD) begin
         pcE         <= pcF;
         instrE      <= instrD;
         regWriteE   <= regWriteD;
         memWriteE   <= memWriteD;
         memToRegE   <= memToRegD;
         aluSrcImmE  <= aluSrcImmD;
         jumpE       <= jumpD;
         jalrE       <= jalrD;
         auipcE      <= auipcD;
         luiE        <= luiD;
         branchTypeE <= branchTypeD;
         aluCtrlE    <= aluCtrlD;
         immSelE     <= immSelD;
         csrOpE      <= csrOpD;
         csrUimmE    <= csrUimmD;
      end
   end

endmodule

// File: hw/cpu6Datapath.sv
`timescale 1ns/1ps

module cpu6Datapath (
   input  logic             clk,
   input  logic             rstN,
   input  logic             validE,
   input  logic             regWriteE,
   input  logic             memWriteE,
   input  logic             memToRegE,
   input  logic             aluSrcImmE,
   input  logic             jumpE,
   input  logic             jalrE,
   input  logic             auipcE,
   input  logic             luiE,
   input  cpu6Pkg::branchT  branchTypeE,
   input  cpu6Pkg::aluCtrlT aluCtrlE,
   input  cpu6Pkg::immSelT  immSelE,
   input  cpu6Pkg::csrOpT   csrOpE,
   input  logic             csrUimmE,
   input  cpu6Pkg::wordT    pcE,
   input  cpu6Pkg::wordT    instrE,
   input  logic             trapEna,
   input  cpu6Pkg::wordT    trapCause,
   input  cpu6Pkg::wordT    trapPc,
   input  logic             mretTake,
   input  cpu6Pkg::wordT    readData,
   output cpu6Pkg::wordT    pcNextE,
   output logic             pcSrcE,
   output logic             csrInE,
   output cpu6Pkg::wordT    dataAddr,
   output cpu6Pkg::wordT    writeData,
   output logic             memWrite,
   output logic             memRead,
   output cpu6Pkg::wordT    mtvec,
   output cpu6Pkg::wordT    mepc,
   output logic             mstatusMie,
   output logic             mieMtie,
   output logic             mieMeie
);
   import cpu6Pkg::*;

   wordT    regFile [0:31];
   regIdxT  rs1Idx;
   regIdxT  rs2Idx;
   regIdxT  rdIdx;
   csrAddrT csrAddr;
   wordT    rs1;
   wordT    rs2;
   wordT    imm;
   wordT    aluA;
   wordT    aluB;
   wordT    aluResult;
   wordT    wbData;
   wordT    csrOld;
   wordT    csrNew;
   wordT    mcause;
   logic    mpie;
   logic    taken;

   assign rs1Idx  = instrE[19:15];
   assign rs2Idx  = instrE[24:20];
   assign rdIdx   = instrE[11:7];
   assign csrAddr = instrE[31:20];

   assign rs1 = (rs1Idx == '0) ? '0 : regFile[rs1Idx];
   assign rs2 = (rs2Idx == '0) ? '0 : regFile[rs2Idx];

   always_comb begin
      case (immSelE)
         ImmI:    imm = {{20{instrE[31]}}, instrE[31:20]};
         ImmS:    imm = {{20{instrE[31]}}, instrE[31:25], instrE[11:7]};
         ImmB:    imm = {{19{instrE[31]}}, instrE[31], instrE[7], instrE[30:25],
                         instrE[11:8], 1'b0};
         ImmU:    imm = {instrE[31:12], 12'b0};
         ImmJ:    imm = {{11{instrE[31]}}, instrE[31], instrE[19:12], instrE[20],
                         instrE[30:21], 1'b0};
         ImmCsr:  imm = {27'b0, instrE[19:15]};
         default: imm = '0;
      endcase
   end

   // for CSR instructions the ALU passes the source operand through
   assign aluA = luiE ? '0 : (auipcE ? pcE : rs1);
   assign aluB = (csrOpE != CsrNone) ? (csrUimmE ? imm : rs1) : (aluSrcImmE ? imm : rs2);

   always_comb begin
      case (aluCtrlE)
         AluSub:   aluResult = aluA - aluB;
         AluAnd:   aluResult = aluA & aluB;
         AluOr:    aluResult = aluA | aluB;
         AluXor:   aluResult = aluA ^ aluB;
         AluSll:   aluResult = aluA << aluB[4:0];
         AluSrl:   aluResult = aluA >> aluB[4:0];
         AluSra:   aluResult = $signed(aluA) >>> aluB[4:0];
         AluSlt:   aluResult = {{(Xlen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
         AluSltu:  aluResult = {{(Xlen-1){1'b0}}, aluA < aluB};
         AluPassB: aluResult = aluB;
         default:  aluResult = aluA + aluB;
      endcase
   end

   always_comb begin
      case (branchTypeE)
         BrEq:    taken = (rs1 == rs2);
         BrNe:    taken = (rs1 != rs2);
         BrLt:    taken = ($signed(rs1) < $signed(rs2));
         BrGe:    taken = ($signed(rs1) >= $signed(rs2));
         BrLtu:   taken = (rs1 < rs2);
         BrGeu:   taken = (rs1 >= rs2);
         default: taken = 1'b0;
      endcase
   end

   assign pcSrcE  = validE & (jumpE | taken);
   assign pcNextE = jalrE ? ((rs1 + imm) & ~wordT'(1)) : (pcE + imm);

   assign dataAddr  = aluResult;
   assign writeData = rs2;
   assign memWrite  = validE & memWriteE;
   assign memRead   = validE & memToRegE;

   assign csrInE = validE & (csrOpE != CsrNone);

   always_comb begin
      case (csrAddr)
         CsrMstatus: csrOld = {24'b0, mpie, 3'b0, mstatusMie, 3'b0};
         CsrMie:     csrOld = {20'b0, mieMeie, 3'b0, mieMtie, 7'b0};
         CsrMtvec:   csrOld = mtvec;
         CsrMepc:    csrOld = mepc;
         CsrMcause:  csrOld = mcause;
         default:    csrOld = '0;
      endcase
      case (csrOpE)
         CsrWrite: csrNew = aluResult;
         CsrSet:   csrNew = csrOld | aluResult;
         CsrClear: csrNew = csrOld & ~aluResult;
         default:  csrNew = csrOld;
      endcase
   end

   always_comb begin
      if (memToRegE)
         wbData = readData;
      else if (jumpE)
         wbData = pcE + wordT'(4);
      else if (csrOpE != CsrNone)
         wbData = csrOld;
      else
         wbData = aluResult;
   end

   // all registers start from zero
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++)
            regFile[i] <= '0;
      end else if (validE && regWriteE && rdIdx != '0) begin
         regFile[rdIdx] <= wbData;
      end
   end

   // trap entry and mret share the edge with decode, never with a CSR access
   always_ff @(posedge clk) begin
      if (!rstN) begin
         mstatusMie <= 1'b0;
         mpie       <= 1'b0;
         mieMtie    <= 1'b0;
         mieMeie    <= 1'b0;
         mtvec      <= ResetVec;
         mcause     <= '0;
      end else if (trapEna) begin
         mpie       <= mstatusMie;
         mstatusMie <= 1'b0;
         mcause     <= trapCause;
      end else if (mretTake) begin
         mstatusMie <= mpie;
         mpie       <= 1'b1;
      end else if (csrInE) begin
         case (csrAddr)
            CsrMstatus: begin
               mstatusMie <= csrNew[3];
               mpie       <= csrNew[7];
            end
            CsrMie: begin
               mieMtie <= csrNew[7];
               mieMeie <= csrNew[11];
            end
            // direct mode only
            CsrMtvec:  mtvec  <= {csrNew[Xlen-1:2], 2'b00};
            CsrMcause: mcause <= csrNew;
            default:   mcause <= mcause;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (trapEna)
         mepc <= trapPc;
      else if (csrInE && csrAddr == CsrMepc)
         mepc <= csrNew;
   end

endmodule

// File: hw/cpu6Excp.sv
`timescale 1ns/1ps

module cpu6Excp (
   input  logic          clk,
   input  logic          rstN,
   input  logic          decValid,
   input  logic          illInstr,
   input  logic          mret,
   input  logic          holdTrap,
   input  logic          tmrIrq,
   input  logic          extIrq,
   input  logic          mstatusMie,
   input  logic          mieMtie,
   input  logic          mieMeie,
   input  cpu6Pkg::wordT pcD,
   input  cpu6Pkg::wordT mtvec,
   input  cpu6Pkg::wordT mepc,
   output logic          flushPcEna,
   output logic          trapEna,
   output logic          irqTake,
   output logic          mretTake,
   output cpu6Pkg::wordT flushPc,
   output cpu6Pkg::wordT trapCause,
   output cpu6Pkg::wordT trapPc
);
   import cpu6Pkg::*;

   logic tmrIrqR;
   logic extIrqR;
   logic extPend;
   logic tmrPend;
   logic accept;

   // interrupt lines are sampled once before use
   always_ff @(posedge clk) begin
      if (!rstN) begin
         tmrIrqR <= 1'b0;
         extIrqR <= 1'b0;
      end else begin
         tmrIrqR <= tmrIrq;
         extIrqR <= extIrq;
      end
   end

   assign extPend = mstatusMie & mieMeie & extIrqR;
   assign tmrPend = mstatusMie & mieMtie & tmrIrqR;

   // nothing is taken on a flushed slot or while a CSR access finishes
   assign accept = decValid & ~holdTrap;

   // priority: external, timer, illegal, mret
   assign irqTake  = accept & (extPend | tmrPend);
   assign trapEna  = irqTake | (accept & illInstr);
   assign mretTake = accept & mret & ~(extPend | tmrPend);

   assign trapCause = extPend ? CauseExternal : (tmrPend ? CauseTimer : CauseIllegal);
   assign trapPc    = pcD;

   assign flushPcEna = trapEna | mretTake;
   assign flushPc    = mretTake ? mepc : mtvec;

endmodule

// File: hw/cpu6Controller.sv
`timescale 1ns/1ps

module cpu6Controller (
   input  cpu6Pkg::wordT    instr,
   output logic             regWrite,
   output logic             memWrite,
   output logic             memToReg,
   output logic             aluSrcImm,
   output logic             jump,
   output logic             jalr,
   output logic             auipc,
   output logic             lui,
   output logic             mret,
   output cpu6Pkg::branchT  branchType,
   output cpu6Pkg::aluCtrlT aluCtrl,
   output cpu6Pkg::immSelT  immSel,
   output cpu6Pkg::csrOpT   csrOp,
   output logic             csrUimm,
   output logic             illInstr
);
   import cpu6Pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       isReg;
   logic       alt;
   logic       csrKnown;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign isReg  = (opcode == OpReg);
   assign alt    = (funct7 == 7'b0100000);

   // only the five machine-mode CSRs exist
   assign csrKnown = instr[31:20] inside {CsrMstatus, CsrMie, CsrMtvec, CsrMepc, CsrMcause};

   always_comb begin
      regWrite   = 1'b0;
      memWrite   = 1'b0;
      memToReg   = 1'b0;
      aluSrcImm  = 1'b0;
      jump       = 1'b0;
      jalr       = 1'b0;
      auipc      = 1'b0;
      lui        = 1'b0;
      mret       = 1'b0;
      branchType = BrNone;
      aluCtrl    = AluAdd;
      immSel     = ImmI;
      csrOp      = CsrNone;
      csrUimm    = 1'b0;
      illInstr   = 1'b0;
      case (opcode)
         OpLui, OpAuipc: begin
            regWrite = 1'b1;
            aluSrcImm = 1'b1;
            immSel = ImmU;
            lui = (opcode == OpLui);
            auipc = (opcode == OpAuipc);
         end
         OpJal: begin
            regWrite = 1'b1;
            jump = 1'b1;
            immSel = ImmJ;
         end
         OpJalr: begin
            regWrite = 1'b1;
            jump = 1'b1;
            jalr = 1'b1;
            illInstr = (funct3 != 3'b000);
         end
         OpBranch: begin
            immSel = ImmB;
            case (funct3)
               3'b000: branchType = BrEq;
               3'b001: branchType = BrNe;
               3'b100: branchType = BrLt;
               3'b101: branchType = BrGe;
               3'b110: branchType = BrLtu;
               3'b111: branchType = BrGeu;
               default: illInstr = 1'b1;
            endcase
         end
         OpLoad, OpStore: begin
            // word accesses only
            regWrite = (opcode == OpLoad);
            memToReg = (opcode == OpLoad);
            memWrite = (opcode == OpStore);
            aluSrcImm = 1'b1;
            immSel = (opcode == OpStore) ? ImmS : ImmI;
            illInstr = (funct3 != 3'b010);
         end
         OpImm, OpReg: begin
            regWrite = 1'b1;
            aluSrcImm = ~isReg;
            case (funct3)
               3'b000: aluCtrl = (isReg && alt) ? AluSub : AluAdd;
               3'b001: aluCtrl = AluSll;
               3'b010: aluCtrl = AluSlt;
               3'b011: aluCtrl = AluSltu;
               3'b100: aluCtrl = AluXor;
               3'b101: aluCtrl = alt ? AluSra : AluSrl;
               3'b110: aluCtrl = AluOr;
               default: aluCtrl = AluAnd;
            endcase
            // funct7 is only an immediate for non-shift OP-IMM
            if ((isReg || funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0 &&
                !(alt && (funct3 == 3'b101 || (isReg && funct3 == 3'b000))))
               illInstr = 1'b1;
         end
         OpSystem: begin
            if (instr == 32'h3020_0073) begin
               mret = 1'b1;
            end else begin
               regWrite = 1'b1;
               immSel = ImmCsr;
               aluCtrl = AluPassB;
               csrUimm = funct3[2];
               case (funct3[1:0])
                  2'b01: csrOp = CsrWrite;
                  2'b10: csrOp = CsrSet;
                  2'b11: csrOp = CsrClear;
                  default: illInstr = 1'b1;
               endcase
               if (!csrKnown)
                  illInstr = 1'b1;
            end
         end
         default: illInstr = 1'b1;
      endcase
      // an illegal word must leave no trace in the machine
      if (illInstr) begin
         regWrite = 1'b0;
         memWrite = 1'b0;
         memToReg = 1'b0;
         jump = 1'b0;
         jalr = 1'b0;
         mret = 1'b0;
         branchType = BrNone;
         csrOp = CsrNone;
      end
   end

endmodule

// File: hw/cpu6Pkg.sv
package cpu6Pkg;

   localparam int Xlen = 32;

   typedef logic [Xlen-1:0] wordT;
   typedef logic [4:0]      regIdxT;
   typedef logic [3:0]      aluCtrlT;
   typedef logic [2:0]      branchT;
   typedef logic [2:0]      immSelT;
   typedef logic [1:0]      csrOpT;
   typedef logic [11:0]     csrAddrT;

   // addi x0,x0,0
   localparam wordT Nop      = 32'h0000_0013;
   localparam wordT ResetVec = 32'h0000_0000;

   // major opcodes, instr[6:0]
   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpAuipc  = 7'b0010111;
   localparam logic [6:0] OpJal    = 7'b1101111;
   localparam logic [6:0] OpJalr   = 7'b1100111;
   localparam logic [6:0] OpBranch = 7'b1100011;
   localparam logic [6:0] OpLoad   = 7'b0000011;
   localparam logic [6:0] OpStore  = 7'b0100011;
   localparam logic [6:0] OpImm    = 7'b0010011;
   localparam logic [6:0] OpReg    = 7'b0110011;
   localparam logic [6:0] OpSystem = 7'b1110011;

   localparam aluCtrlT AluAdd   = 4'd0;
   localparam aluCtrlT AluSub   = 4'd1;
   localparam aluCtrlT AluAnd   = 4'd2;
   localparam aluCtrlT AluOr    = 4'd3;
   localparam aluCtrlT AluXor   = 4'd4;
   localparam aluCtrlT AluSll   = 4'd5;
   localparam aluCtrlT AluSrl   = 4'd6;
   localparam aluCtrlT AluSra   = 4'd7;
   localparam aluCtrlT AluSlt   = 4'd8;
   localparam aluCtrlT AluSltu  = 4'd9;
   localparam aluCtrlT AluPassB = 4'd10;

   localparam branchT BrNone = 3'd0;
   localparam branchT BrEq   = 3'd1;
   localparam branchT BrNe   = 3'd2;
   localparam branchT BrLt   = 3'd3;
   localparam branchT BrGe   = 3'd4;
   localparam branchT BrLtu  = 3'd5;
   localparam branchT BrGeu  = 3'd6;

   localparam immSelT ImmI   = 3'd0;
   localparam immSelT ImmS   = 3'd1;
   localparam immSelT ImmB   = 3'd2;
   localparam immSelT ImmU   = 3'd3;
   localparam immSelT ImmJ   = 3'd4;
   // zero-extended rs1 field of csrrwi/csrrsi/csrrci
   localparam immSelT ImmCsr = 3'd5;

   localparam csrOpT CsrNone  = 2'd0;
   localparam csrOpT CsrWrite = 2'd1;
   localparam csrOpT CsrSet   = 2'd2;
   localparam csrOpT CsrClear = 2'd3;

   localparam csrAddrT CsrMstatus = 12'h300;
   localparam csrAddrT CsrMie     = 12'h304;
   localparam csrAddrT CsrMtvec   = 12'h305;
   localparam csrAddrT CsrMepc    = 12'h341;
   localparam csrAddrT CsrMcause  = 12'h342;

   // interrupt causes carry the top bit
   localparam wordT CauseIllegal  = 32'h0000_0002;
   localparam wordT CauseTimer    = 32'h8000_0007;
   localparam wordT CauseExternal = 32'h8000_000B;

   // mtime at TimerBase, mtimecmp at TimerBase+4
   localparam wordT TimerBase = 32'h1000_0000;

endpackage
